/* rtl/modbus_pkg.sv */
`default_nettype none

package modbus_pkg;

  // Serial byte as delivered by the UART.
  typedef logic [7:0] byte_t;

  typedef logic [7:0] slave_addr_t;

  // Register file side of the bus.
  typedef logic [15:0] reg_addr_t;
  typedef logic [15:0] reg_data_t;
  typedef logic [15:0] reg_count_t;

  typedef logic [15:0] crc_t;

  localparam byte_t FN_READ_HOLDING = 8'd3;

  // CRC-16/Modbus uses the reflected form of 0x8005.
  localparam crc_t CRC_INIT = 16'hFFFF;
  localparam crc_t CRC_POLY = 16'hA001;

  localparam reg_count_t MAX_READ_COUNT = 16'd125; // Largest count a reply can carry.

  localparam int REQ_LENGTH = 8; // Address, function, start, count, CRC.

endpackage

`default_nettype wire

/* rtl/modbus_crc.sv */
`timescale 1ns/100ps
`default_nettype none

module modbus_crc (
  input  logic                clk,
  input  logic                rst,
  input  logic                clear,
  input  logic                enable,
  input  modbus_pkg::byte_t   din,
  output modbus_pkg::crc_t    crc
);
  import modbus_pkg::*;

  // One whole byte per call, LSB first as the line sends it.
  function automatic crc_t crc_fold(crc_t crc_in, byte_t data);
    crc_t acc;
    acc = crc_in ^ crc_t'(data);
    for (int i = 0; i < 8; i++)
    begin
      acc = acc[0] ? ((acc >> 1) ^ CRC_POLY) : (acc >> 1);
    end
    return acc;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      crc <= CRC_INIT;
    else if (clear)
      crc <= enable ? crc_fold(CRC_INIT, din) : CRC_INIT; // First byte of a frame.
    else if (enable)
      crc <= crc_fold(crc, din);
  end

  a_crc_known : assert property (@(posedge clk) disable iff (rst) !$isunknown(crc))
    else $error("CRC register went unknown");

endmodule

`default_nettype wire

/* rtl/modbus_frame_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module modbus_frame_rx (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      ready,
  input  logic                      rxerr,
  input  logic                      resp_busy,
  input  modbus_pkg::byte_t         din,
  output logic                      frame_start,
  output logic                      crc_enable,
  output logic                      frame_done,
  output modbus_pkg::slave_addr_t   req_slave,
  output modbus_pkg::byte_t         req_function,
  output modbus_pkg::reg_addr_t     req_start,
  output modbus_pkg::reg_count_t    req_count,
  output modbus_pkg::crc_t          req_crc
);
  import modbus_pkg::*;

  typedef enum logic {
    RX_IDLE,
    RX_COLLECT
  } rx_state_t;

  rx_state_t  state;
  logic [2:0] byte_idx;
  logic       take;

  // The done cycle is blocked too, since the controller only raises
  // resp_busy one cycle later and req_slave would be overwritten.
  assign take = ready && !rxerr && !resp_busy && !frame_done;

  assign frame_start = take && (state == RX_IDLE);

  // The two trailing CRC bytes are not part of the checked data.
  assign crc_enable = take && (byte_idx < 3'd6);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state      <= RX_IDLE;
      byte_idx   <= '0;
      frame_done <= 1'b0;
    end
    else
    begin
      frame_done <= 1'b0;
      if (ready && rxerr)
      begin
        state    <= RX_IDLE; // Line error, drop whatever was collected.
        byte_idx <= '0;
      end
      else if (take)
      begin
        if (byte_idx == 3'(REQ_LENGTH - 1))
        begin
          state      <= RX_IDLE;
          byte_idx   <= '0;
          frame_done <= 1'b1;
        end
        else
        begin
          state    <= RX_COLLECT;
          byte_idx <= byte_idx + 3'd1;
        end
      end
    end
  end

  // Request fields are big-endian on the wire. The CRC comes low byte first.
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      case (byte_idx)
        3'd0: req_slave          <= din;
        3'd1: req_function       <= din;
        3'd2: req_start[15:8]    <= din;
        3'd3: req_start[7:0]     <= din;
        3'd4: req_count[15:8]    <= din;
        3'd5: req_count[7:0]     <= din;
        3'd6: req_crc[7:0]       <= din;
        3'd7: req_crc[15:8]      <= din;
        default: req_slave       <= req_slave;
      endcase
    end
  end

  // The fields are only safe once the controller holds off new bytes.
  a_busy_after_done : assert property (@(posedge clk) disable iff (rst)
    frame_done |=> resp_busy)
    else $error("Finished frame was not taken up by the controller");

endmodule

`default_nettype wire

/* rtl/modbus_resp_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module modbus_resp_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      frame_done,
  input  logic                      txbusy,
  input  logic                      ack,
  input  modbus_pkg::slave_addr_t   maddr,
  input  modbus_pkg::slave_addr_t   req_slave,
  input  modbus_pkg::byte_t         req_function,
  input  modbus_pkg::reg_addr_t     req_start,
  input  modbus_pkg::reg_count_t    req_count,
  input  modbus_pkg::crc_t          req_crc,
  input  modbus_pkg::crc_t          calc_crc,
  input  modbus_pkg::reg_data_t     rdata,
  output logic                      resp_busy,
  output logic                      send,
  output logic                      valid,
  output modbus_pkg::byte_t         dout,
  output modbus_pkg::reg_addr_t     raddr
);
  import modbus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CHECK,
    ST_HEADER,
    ST_READ,
    ST_DATA_HI,
    ST_DATA_LO,
    ST_CRC_LO,
    ST_CRC_HI
  } state_t;

  state_t     state;
  logic [1:0] hdr_idx;
  reg_count_t regs_left;
  reg_data_t  data_q;
  crc_t       rx_crc_q;
  crc_t       tx_crc;
  byte_t      byte_count;
  logic       guard;
  logic       txbusy_q;
  logic       tx_state;
  logic       req_ok;
  logic       tx_clear;
  logic       tx_fold;

  assign byte_count = {req_count[6:0], 1'b0}; // Count is at most 125 here.

  assign req_ok = (req_slave == maddr) && (req_function == FN_READ_HOLDING) &&
                  (req_count != '0) && (req_count <= MAX_READ_COUNT) &&
                  (req_crc == rx_crc_q);

  assign tx_state = (state == ST_HEADER) || (state == ST_DATA_HI) ||
                    (state == ST_DATA_LO) || (state == ST_CRC_LO) || (state == ST_CRC_HI);

  // The transmitter must have been idle for two samples, and the cycle right
  // after a pulse is skipped while txbusy catches up.
  assign send      = tx_state && !guard && !txbusy && !txbusy_q;
  assign valid     = (state == ST_READ);
  assign resp_busy = (state != ST_IDLE);

  always_comb
  begin
    case (state)
      ST_HEADER:  dout = (hdr_idx == 2'd0) ? maddr :
                         (hdr_idx == 2'd1) ? FN_READ_HOLDING : byte_count;
      ST_DATA_HI: dout = data_q[15:8];
      ST_DATA_LO: dout = data_q[7:0];
      ST_CRC_LO:  dout = tx_crc[7:0];
      ST_CRC_HI:  dout = tx_crc[15:8];
      default:    dout = '0;
    endcase
  end

  // Everything sent before the CRC bytes goes into the reply CRC.
  assign tx_clear = (state == ST_CHECK) && req_ok;
  assign tx_fold  = send && ((state == ST_HEADER) || (state == ST_DATA_HI) ||
                             (state == ST_DATA_LO));

  modbus_crc u_tx_crc (
    .clk    (clk),
    .rst    (rst),
    .clear  (tx_clear),
    .enable (tx_fold),
    .din    (dout),
    .crc    (tx_crc)
  );

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= ST_IDLE;
      hdr_idx  <= '0;
      guard    <= 1'b0;
      txbusy_q <= 1'b0;
    end
    else
    begin
      guard    <= send;
      txbusy_q <= txbusy;
      case (state)
        ST_IDLE:    if (frame_done) state <= ST_CHECK;
        ST_CHECK:
        begin
          hdr_idx <= '0;
          state   <= req_ok ? ST_HEADER : ST_IDLE; // Bad requests get no answer.
        end
        ST_HEADER:
          if (send)
          begin
            if (hdr_idx == 2'd2)
              state <= ST_READ;
            else
              hdr_idx <= hdr_idx + 2'd1;
          end
        ST_READ:    if (ack) state <= ST_DATA_HI;
        ST_DATA_HI: if (send) state <= ST_DATA_LO;
        ST_DATA_LO: if (send) state <= (regs_left == 16'd1) ? ST_CRC_LO : ST_READ;
        ST_CRC_LO:  if (send) state <= ST_CRC_HI;
        ST_CRC_HI:  if (send) state <= ST_IDLE;
        default:    state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == ST_IDLE) && frame_done)
      rx_crc_q <= calc_crc;
    if (state == ST_CHECK)
    begin
      raddr     <= req_start;
      regs_left <= req_count;
    end
    if ((state == ST_READ) && ack)
      data_q <= rdata;
    if ((state == ST_DATA_LO) && send)
    begin
      raddr     <= raddr + 16'd1; // Next register once both data bytes are out.
      regs_left <= regs_left - 16'd1;
    end
  end

  // A byte held back by the transmitter must go out unchanged.
  a_hold_byte : assert property (@(posedge clk) disable iff (rst)
    tx_state && !send |=> tx_state && $stable(dout))
    else $error("Pending reply byte changed before it was sent");

  a_valid_held : assert property (@(posedge clk) disable iff (rst)
    valid && !ack |=> valid && $stable(raddr))
    else $error("Bus read dropped before ack");

endmodule

`default_nettype wire

/* rtl/modbus_endpoint.sv */
`timescale 1ns/100ps
`default_nettype none

module modbus_endpoint (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      ready,
  input  logic                      rxerr,
  input  logic                      txbusy,
  input  logic                      ack,
  input  modbus_pkg::slave_addr_t   maddr,
  input  modbus_pkg::byte_t         din,
  input  modbus_pkg::reg_data_t     rdata,
  output logic                      send,
  output logic                      valid,
  output modbus_pkg::byte_t         dout,
  output modbus_pkg::reg_addr_t     raddr
);
  import modbus_pkg::*;

  logic        frame_start;
  logic        crc_enable;
  logic        frame_done;
  logic        resp_busy;
  slave_addr_t req_slave;
  byte_t       req_function;
  reg_addr_t   req_start;
  reg_count_t  req_count;
  crc_t        req_crc;
  crc_t        calc_crc;

  modbus_frame_rx u_frame_rx (
    .clk          (clk),
    .rst          (rst),
    .ready        (ready),
    .rxerr        (rxerr),
    .resp_busy    (resp_busy),
    .din          (din),
    .frame_start  (frame_start),
    .crc_enable   (crc_enable),
    .frame_done   (frame_done),
    .req_slave    (req_slave),
    .req_function (req_function),
    .req_start    (req_start),
    .req_count    (req_count),
    .req_crc      (req_crc)
  );

  // Runs on the same bytes as the collector and stops before the CRC field.
  modbus_crc u_rx_crc (
    .clk    (clk),
    .rst    (rst),
    .clear  (frame_start),
    .enable (crc_enable),
    .din    (din),
    .crc    (calc_crc)
  );

  modbus_resp_ctrl u_resp_ctrl (
    .clk          (clk),
    .rst          (rst),
    .frame_done   (frame_done),
    .txbusy       (txbusy),
    .ack          (ack),
    .maddr        (maddr),
    .req_slave    (req_slave),
    .req_function (req_function),
    .req_start    (req_start),
    .req_count    (req_count),
    .req_crc      (req_crc),
    .calc_crc     (calc_crc),
    .rdata        (rdata),
    .resp_busy    (resp_busy),
    .send         (send),
    .valid        (valid),
    .dout         (dout),
    .raddr        (raddr)
  );

endmodule

`default_nettype wire

/* dv/tb_modbus_endpoint.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_modbus_endpoint;

  localparam int MAX_TESTS = 32;
  localparam int FIELDS = 7;

  logic        clk = 1'b0;
  logic        rst;
  logic        ready;
  logic        rxerr;
  logic        txbusy;
  logic        ack;
  logic [7:0]  maddr;
  logic [7:0]  din;
  logic [15:0] rdata;
  logic        send;
  logic        valid;
  logic [7:0]  dout;
  logic [15:0] raddr;

  logic [15:0] vec [0:FIELDS*MAX_TESTS-1];
  logic [7:0]  got_bytes [$];
  logic [15:0] read_addrs [$];
  logic [7:0]  exp_bytes [0:255];
  logic [31:0] busy_seed;
  logic [31:0] ack_seed;
  int          busy_left;
  int          ack_wait;
  logic        ack_pending;
  int          errors = 0;
  int          failed_tests = 0;
  int          num_tests = 0;

  modbus_endpoint UUT (
    .clk    (clk),
    .rst    (rst),
    .ready  (ready),
    .rxerr  (rxerr),
    .txbusy (txbusy),
    .ack    (ack),
    .maddr  (maddr),
    .din    (din),
    .rdata  (rdata),
    .send   (send),
    .valid  (valid),
    .dout   (dout),
    .raddr  (raddr)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Bit-serial CRC-16/Modbus, LSB of each byte first.
  function automatic logic [15:0] crc16_step(logic [15:0] crc, logic [7:0] b);
    logic fb;
    for (int i = 0; i < 8; i++)
    begin
      fb  = crc[0] ^ b[i];
      crc = crc >> 1;
      if (fb)
        crc = crc ^ 16'hA001;
    end
    return crc;
  endfunction

  // Transmitter goes busy the cycle after each byte and holds for 1 to 6 cycles.
  always @(posedge clk)
  begin
    if (rst)
    begin
      txbusy    <= 1'b0;
      busy_left = 0;
    end
    else if (send)
    begin
      assert (!txbusy)
      else
      begin
        $display("ERROR at %0t ns: send got 1 expected 0 while txbusy high", $time);
        errors++;
      end
      got_bytes.push_back(dout);
      busy_seed = lcg_step(busy_seed);
      busy_left = 1 + (busy_seed[23:16] % 6);
      txbusy    <= 1'b1;
    end
    else if (busy_left > 0)
    begin
      busy_left--;
      if (busy_left == 0)
        txbusy <= 1'b0;
    end
  end

  // Register bus answers each read after 0 to 3 cycles with raddr ^ A5A5.
  always @(posedge clk)
  begin
    if (rst)
    begin
      ack         <= 1'b0;
      ack_pending = 1'b0;
    end
    else if (ack)
      ack <= 1'b0;
    else if (valid)
    begin
      if (!ack_pending)
      begin
        ack_pending = 1'b1;
        ack_seed    = lcg_step(ack_seed);
        ack_wait    = ack_seed[17:16];
        read_addrs.push_back(raddr);
      end
      if (ack_wait == 0)
      begin
        ack         <= 1'b1;
        rdata       <= raddr ^ 16'hA5A5;
        ack_pending = 1'b0;
      end
      else
        ack_wait--;
    end
  end

  task automatic put_byte(input logic [7:0] b, input logic err);
    @(posedge clk);
    din   <= b;
    ready <= 1'b1;
    rxerr <= err;
    @(posedge clk);
    ready <= 1'b0;
    rxerr <= 1'b0;
  endtask

  task automatic run_test(input int n);
    logic [7:0]  req [0:7];
    logic [15:0] start;
    logic [15:0] count;
    logic [15:0] crc;
    logic        expect_reply;
    int          len;
    int          cycles;
    int          errs_before;
    errs_before  = errors;
    start        = vec[FIELDS*n+2];
    count        = vec[FIELDS*n+3];
    expect_reply = vec[FIELDS*n+6][0];
    got_bytes.delete();
    read_addrs.delete();
    req[0] = vec[FIELDS*n][7:0];
    req[1] = vec[FIELDS*n+1][7:0];
    req[2] = start[15:8];
    req[3] = start[7:0];
    req[4] = count[15:8];
    req[5] = count[7:0];
    crc = 16'hFFFF;
    for (int i = 0; i < 6; i++)
      crc = crc16_step(crc, req[i]);
    if (vec[FIELDS*n+4][0])
      crc = crc ^ 16'h00FF; // Damaged checksum.
    req[6] = crc[7:0];
    req[7] = crc[15:8];
    if (vec[FIELDS*n+5][0])
    begin
      for (int i = 0; i < 4; i++)
        put_byte(req[i], i == 3); // Line error on the fourth byte.
    end
    else
    begin
      for (int i = 0; i < 8; i++)
        put_byte(req[i], 1'b0);
    end

    len = expect_reply ? 5 + 2 * count : 0;
    if (expect_reply)
    begin
      exp_bytes[0] = req[0];
      exp_bytes[1] = 8'd3;
      exp_bytes[2] = 8'(2 * count);
      for (int i = 0; i < count; i++)
        {exp_bytes[3 + 2 * i], exp_bytes[4 + 2 * i]} = (start + 16'(i)) ^ 16'hA5A5;
      crc = 16'hFFFF;
      for (int i = 0; i < len - 2; i++)
        crc = crc16_step(crc, exp_bytes[i]);
      exp_bytes[len - 2] = crc[7:0];
      exp_bytes[len - 1] = crc[15:8];
    end

    cycles = 0;
    while (got_bytes.size() < len && cycles < 8000)
    begin
      @(posedge clk);
      cycles++;
    end
    assert (got_bytes.size() >= len)
    else
    begin
      $display("Test %0d: reply did not arrive, %0d of %0d bytes seen", n,
               got_bytes.size(), len);
      errors++;
    end
    repeat (40) @(posedge clk); // Quiet window catches stray bytes and reads.

    assert (got_bytes.size() == len)
    else
    begin
      $display("ERROR at %0t ns: send count got %0d expected %0d", $time, got_bytes.size(), len);
      errors++;
    end
    assert (read_addrs.size() == (expect_reply ? count : 0))
    else
    begin
      $display("ERROR at %0t ns: valid reads got %0d expected %0d", $time, read_addrs.size(),
               expect_reply ? count : 0);
      errors++;
    end
    for (int i = 0; i < len && i < got_bytes.size(); i++)
      assert (got_bytes[i] == exp_bytes[i])
      else
      begin
        $display("ERROR at %0t ns: dout[%0d] got %02h expected %02h", $time, i,
                 got_bytes[i], exp_bytes[i]);
        errors++;
      end
    for (int i = 0; i < read_addrs.size() && expect_reply; i++)
      assert (read_addrs[i] == 16'(start + i))
      else
      begin
        $display("ERROR at %0t ns: raddr read %0d got %04h expected %04h", $time, i,
                 read_addrs[i], 16'(start + i));
        errors++;
      end

    if (errors != errs_before)
      failed_tests++;
    $display("Test %0d: slave %02h fn %02h start %04h count %0d -> %s", n, req[0], req[1],
             start, count, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  initial
  begin
    rst       = 1'b1;
    ready     = 1'b0;
    rxerr     = 1'b0;
    txbusy    = 1'b0;
    ack       = 1'b0;
    maddr     = 8'h05;
    din       = 8'h00;
    rdata     = 16'h0000;
    busy_seed = 32'd71;
    ack_seed  = lcg_step(32'd71);
    $readmemh("dv/modbus_testdata.txt", vec);
    while (num_tests < MAX_TESTS && !$isunknown(vec[FIELDS * num_tests]))
      num_tests++;

    fork
      begin
        #(num_tests * 5000);
        $display("Watchdog expired, the tests did not finish in time.");
        $display("sim failed");
        $finish;
      end
    join_none

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (!send && !valid)
    else
    begin
      $display("ERROR at %0t ns: send/valid got %b%b expected 00 after reset", $time,
               send, valid);
      errors++;
    end
    assert (num_tests > 0)
    else
    begin
      $display("No test vectors could be read from the data file.");
      errors++;
    end

    for (int n = 0; n < num_tests; n++)
      run_test(n);

    $display("%0d tests run, %0d failed, %0d errors", num_tests, failed_tests, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* modbus_endpoint.f */
rtl/modbus_pkg.sv
rtl/modbus_crc.sv
rtl/modbus_frame_rx.sv
rtl/modbus_resp_ctrl.sv
rtl/modbus_endpoint.sv
dv/tb_modbus_endpoint.sv

/* Bender.yml */
package:
  name: modbus_endpoint

sources:
  - files:
      - rtl/modbus_pkg.sv
      - rtl/modbus_crc.sv
      - rtl/modbus_frame_rx.sv
      - rtl/modbus_resp_ctrl.sv
      - rtl/modbus_endpoint.sv
  - target: test
    files:
      - dv/tb_modbus_endpoint.sv

/* dv/modbus_testdata.txt */
// slave function start count bad_crc rxerr reply_expected
// All columns hex, one request per line.
05 03 0000 0001 0 0 1
05 03 0010 0004 0 0 1
05 03 1234 007D 0 0 1
07 03 0000 0001 0 0 0
05 04 0000 0001 0 0 0
05 03 0000 0000 0 0 0
05 03 0000 007E 0 0 0
05 03 0000 0002 1 0 0
05 03 0020 0002 0 1 0
05 03 0020 0002 0 0 1
05 03 FFFE 0003 0 0 1
05 10 0001 0001 0 0 0
05 03 0100 0008 0 0 1
